// File: src/ln_pkg.sv
package ln_pkg;

    localparam int LANES    = 8;
    localparam int LANE_LOG = $clog2(LANES);

    // enough headroom for 256 beats of 8 lanes
    localparam int ACC_W = 24;

    typedef logic signed [7:0]       elem_t;
    typedef logic signed [8:0]       centered_t;
    typedef logic signed [16:0]      prod_t;
    typedef logic signed [10:0]      tree_sum_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [3:0]              shift_t;

    // lane 0 in the low byte
    typedef elem_t [LANES-1:0] lane_vec_t;

    typedef struct packed {
        lane_vec_t data;
        lane_vec_t gamma;
        lane_vec_t beta;
    } beat_t;

    typedef enum logic [1:0] {
        COLLECT,
        WAIT_MEAN,
        REPLAY
    } phase_t;

endpackage

// File: src/adder_tree.sv
`timescale 1ns/1ps

module adder_tree import ln_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  lane_vec_t data,
    input  logic      vld,
    output tree_sum_t sum,
    output logic      sum_vld
);

    localparam int W0 = $bits(elem_t);

    // stage 0 operands, registered
    logic signed [W0-1:0] s0_in  [LANES];
    logic signed [W0:0]   s0_out [LANES/2];
    // stage 1 is purely combinational
    logic signed [W0+1:0] s1_out [LANES/4];
    // stage 2 operands, registered again
    logic signed [W0+1:0] s2_in  [LANES/4];
    logic                 s0_vld;

    always_ff @(posedge clk) begin
        if (vld) begin
            for (int k = 0; k < LANES; k++) begin
                s0_in[k] <= data[k];
            end
        end
    end

    genvar i;
    generate
        for (i = 0; i < LANES/2; i++) begin : g_stage0
            assign s0_out[i] = s0_in[2*i] + s0_in[2*i+1];
        end
        for (i = 0; i < LANES/4; i++) begin : g_stage1
            assign s1_out[i] = s0_out[2*i] + s0_out[2*i+1];
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (s0_vld) begin
            for (int k = 0; k < LANES/4; k++) begin
                s2_in[k] <= s1_out[k];
            end
        end
    end

    // final add straight off the stage 2 registers
    assign sum = s2_in[0] + s2_in[1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s0_vld  <= 1'b0;
            sum_vld <= 1'b0;
        end else begin
            s0_vld  <= vld;
            sum_vld <= s0_vld;
        end
    end

endmodule

// File: src/mean_accum.sv
`timescale 1ns/1ps

module mean_accum import ln_pkg::*; #(
    parameter int BEATS = 32
) (
    input  logic      clk,
    input  logic      rstn,
    input  tree_sum_t sum,
    input  logic      sum_vld,
    output elem_t     mean,
    output logic      mean_vld
);

    localparam int CNT_W      = $clog2(BEATS);
    localparam int MEAN_SHIFT = CNT_W + LANE_LOG;

    logic [CNT_W-1:0] cnt;
    acc_t             acc;
    acc_t             total;

    // running sum including the beat arriving now
    assign total = acc + acc_t'(sum);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt      <= '0;
            acc      <= '0;
            mean_vld <= 1'b0;
        end else begin
            mean_vld <= 1'b0;
            if (sum_vld) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(BEATS - 1)) begin
                    acc      <= '0;
                    mean_vld <= 1'b1;
                end else begin
                    acc <= total;
                end
            end
        end
    end

    // floor divide by BEATS * LANES
    always_ff @(posedge clk) begin
        if (sum_vld && cnt == CNT_W'(BEATS - 1)) begin
            mean <= elem_t'(total >>> MEAN_SHIFT);
        end
    end

    // one mean per vector, never back to back
    a_mean_single: assert property (@(posedge clk) disable iff (!rstn)
        mean_vld |=> !mean_vld)
        else $error("mean_vld high for two cycles");

endmodule

// File: src/beat_buffer.sv
`timescale 1ns/1ps

module beat_buffer import ln_pkg::*; #(
    parameter int BEATS = 32
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  wr,
    input  beat_t wr_beat,
    input  logic  rd,
    output beat_t rd_beat,
    output logic  rd_vld,
    output logic  rd_last
);

    localparam int PTR_W = $clog2(BEATS);

    beat_t            mem [BEATS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_beat;
        end
        if (rd) begin
            rd_beat <= mem[rd_ptr];
        end
    end

    // pointers wrap naturally since BEATS is a power of two
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            rd_vld  <= 1'b0;
            rd_last <= 1'b0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill    <= fill + (PTR_W+1)'(wr) - (PTR_W+1)'(rd);
            rd_vld  <= rd;
            rd_last <= rd && rd_ptr == PTR_W'(BEATS - 1);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        wr |-> fill != (PTR_W+1)'(BEATS))
        else $error("beat buffer written while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        rd |-> fill != '0)
        else $error("beat buffer read while empty");

endmodule

// File: src/affine_lanes.sv
`timescale 1ns/1ps

module affine_lanes import ln_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  beat_t     beat,
    input  logic      vld,
    input  logic      last,
    input  elem_t     mean,
    input  shift_t    shift,
    output lane_vec_t out_data,
    output logic      out_vld,
    output logic      out_last
);

    localparam int BIAS_W = $bits(prod_t) + 1;

    centered_t               centered [LANES];
    prod_t                   prod     [LANES];
    prod_t                   prod_q   [LANES];
    elem_t                   beta_q   [LANES];
    logic signed [BIAS_W-1:0] biased  [LANES];
    elem_t                   sat      [LANES];
    logic                    vld_q;
    logic                    last_q;

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            centered[l] = beat.data[l] - mean;
            prod[l]     = centered[l] * beat.gamma[l];
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        if (vld) begin
            for (int l = 0; l < LANES; l++) begin
                prod_q[l] <= prod[l];
                beta_q[l] <= beat.beta[l];
            end
        end
    end

    // shift, bias, clamp to int8
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            biased[l] = (prod_q[l] >>> shift) + beta_q[l];
            if (biased[l] > BIAS_W'(127)) begin
                sat[l] = 8'sd127;
            end else if (biased[l] < -BIAS_W'(128)) begin
                sat[l] = -8'sd128;
            end else begin
                sat[l] = elem_t'(biased[l]);
            end
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        if (vld_q) begin
            for (int l = 0; l < LANES; l++) begin
                out_data[l] <= sat[l];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q    <= 1'b0;
            last_q   <= 1'b0;
            out_vld  <= 1'b0;
            out_last <= 1'b0;
        end else begin
            vld_q    <= vld;
            last_q   <= vld && last;
            out_vld  <= vld_q;
            out_last <= last_q;
        end
    end

endmodule

// File: src/layer_norm.sv
`timescale 1ns/1ps

module layer_norm import ln_pkg::*; #(
    parameter int BEATS = 32
) (
    input  logic      clk,
    input  logic      rstn,
    input  beat_t     in_beat,
    input  logic      in_vld,
    input  shift_t    shift_in,
    input  logic      shift_vld,
    output lane_vec_t out_data,
    output logic      out_vld,
    output logic      out_last,
    output logic      busy
);

    localparam int CNT_W = $clog2(BEATS);

    phase_t           phase;
    phase_t           phase_nxt;
    logic             accept;
    logic [CNT_W-1:0] in_cnt;
    logic [CNT_W:0]   rd_cnt;
    logic             rd;
    tree_sum_t        sum;
    logic             sum_vld;
    elem_t            mean;
    logic             mean_vld;
    elem_t            mean_q;
    shift_t           shift_q;
    beat_t            rd_beat;
    logic             rd_vld;
    logic             rd_last;

    // beats outside COLLECT are dropped
    assign accept = in_vld && phase == COLLECT;

    // first read issued alongside mean_vld to keep the 6 cycle latency
    assign rd = (phase == WAIT_MEAN && mean_vld) ||
                (phase == REPLAY && rd_cnt != (CNT_W+1)'(BEATS));

    always_comb begin
        phase_nxt = phase;
        case (phase)
            COLLECT:   if (accept && in_cnt == CNT_W'(BEATS - 1)) phase_nxt = WAIT_MEAN;
            WAIT_MEAN: if (mean_vld) phase_nxt = REPLAY;
            REPLAY:    if (out_last) phase_nxt = COLLECT;
            default:   phase_nxt = COLLECT;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase   <= COLLECT;
            in_cnt  <= '0;
            rd_cnt  <= '0;
            busy    <= 1'b0;
            shift_q <= '0;
        end else begin
            phase <= phase_nxt;
            if (accept) begin
                in_cnt <= in_cnt + 1'b1;
            end
            if (rd) begin
                rd_cnt <= (phase == WAIT_MEAN) ? (CNT_W+1)'(1) : rd_cnt + 1'b1;
            end
            if (out_last) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy <= 1'b1;
            end
            if (shift_vld) begin
                shift_q <= shift_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mean_vld) begin
            mean_q <= mean;
        end
    end

    adder_tree u_tree (
        .clk     (clk),
        .rstn    (rstn),
        .data    (in_beat.data),
        .vld     (accept),
        .sum     (sum),
        .sum_vld (sum_vld)
    );

    mean_accum #(.BEATS(BEATS)) u_mean (
        .clk      (clk),
        .rstn     (rstn),
        .sum      (sum),
        .sum_vld  (sum_vld),
        .mean     (mean),
        .mean_vld (mean_vld)
    );

    beat_buffer #(.BEATS(BEATS)) u_buf (
        .clk     (clk),
        .rstn    (rstn),
        .wr      (accept),
        .wr_beat (in_beat),
        .rd      (rd),
        .rd_beat (rd_beat),
        .rd_vld  (rd_vld),
        .rd_last (rd_last)
    );

    affine_lanes u_affine (
        .clk      (clk),
        .rstn     (rstn),
        .beat     (rd_beat),
        .vld      (rd_vld),
        .last     (rd_last),
        .mean     (mean_q),
        .shift    (shift_q),
        .out_data (out_data),
        .out_vld  (out_vld),
        .out_last (out_last)
    );

    a_in_collect: assert property (@(posedge clk) disable iff (!rstn)
        in_vld |-> phase == COLLECT)
        else $error("input beat outside COLLECT");

    // a shift change mid vector would split the output scaling
    a_shift_idle: assert property (@(posedge clk) disable iff (!rstn)
        shift_vld |-> !busy)
        else $error("out_shift loaded while busy");

endmodule

// File: test/tb_layer_norm.sv
`timescale 1ns/1ps

module tb_layer_norm import ln_pkg::*; ();

    localparam int BEATS      = 8;
    localparam int CLK_HALF   = 2;
    localparam int NUM_VEC    = 9;
    localparam int LIMIT      = NUM_VEC * (BEATS + 12) + 50;
    localparam int MEAN_SHIFT = $clog2(BEATS * LANES);

    logic      clk;
    logic      rstn;
    beat_t     in_beat;
    logic      in_vld;
    shift_t    shift_in;
    logic      shift_vld;
    lane_vec_t out_data;
    logic      out_vld;
    logic      out_last;
    logic      busy;

    logic [31:0] lfsr;
    beat_t       vec [BEATS];
    lane_vec_t   exp_q [$];
    lane_vec_t   exp_beat;
    string       test_name;
    int          errors;
    int          cyc;
    int          last_in_cyc;
    int          out_idx;
    int          out_total;
    logic        started;
    logic        prev_vld;
    logic        prev_last;

    layer_norm #(.BEATS(BEATS)) UUT (
        .clk       (clk),
        .rstn      (rstn),
        .in_beat   (in_beat),
        .in_vld    (in_vld),
        .shift_in  (shift_in),
        .shift_vld (shift_vld),
        .out_data  (out_data),
        .out_vld   (out_vld),
        .out_last  (out_last),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic elem_t rand_elem();
        return elem_t'(take_bits(8));
    endfunction

    function automatic int ref_mean();
        int total;
        total = 0;
        for (int b = 0; b < BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                total += int'(vec[b].data[l]);
            end
        end
        // floors toward minus infinity
        return total >>> MEAN_SHIFT;
    endfunction

    function automatic lane_vec_t ref_beat(beat_t b, int mean, int shift);
        lane_vec_t res;
        int        v;
        for (int l = 0; l < LANES; l++) begin
            v = ((int'(b.data[l]) - mean) * int'(b.gamma[l])) >>> shift;
            v = v + int'(b.beta[l]);
            if (v > 127) begin
                v = 127;
            end else if (v < -128) begin
                v = -128;
            end
            res[l] = elem_t'(v);
        end
        return res;
    endfunction

    task automatic fill_random();
        for (int b = 0; b < BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                vec[b].data[l]  = rand_elem();
                vec[b].gamma[l] = rand_elem();
                vec[b].beta[l]  = rand_elem();
            end
        end
    endtask

    task automatic fill_saturating(elem_t gamma);
        for (int b = 0; b < BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                vec[b].data[l]  = (l % 2 == 0) ? 8'sd127 : -8'sd128;
                vec[b].gamma[l] = gamma;
                vec[b].beta[l]  = rand_elem();
            end
        end
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    // load the shift, then stream one vector of beats
    task automatic run_vector(string name, shift_t shift);
        int mean;
        wait_idle();
        test_name = name;
        mean = ref_mean();
        for (int b = 0; b < BEATS; b++) begin
            exp_q.push_back(ref_beat(vec[b], mean, int'(shift)));
        end
        shift_in  = shift;
        shift_vld = 1'b1;
        @(posedge clk);
        #1;
        shift_vld = 1'b0;
        // the port moves on, the loaded shift must not
        shift_in  = ~shift;
        started   = 1'b1;
        for (int b = 0; b < BEATS; b++) begin
            in_beat = vec[b];
            in_vld  = 1'b1;
            last_in_cyc = cyc;
            @(posedge clk);
            #1;
        end
        in_vld  = 1'b0;
        in_beat = '0;
        if (busy !== 1'b1) begin
            $display("busy not high while %s is in flight", name);
            errors++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            if (!started && (out_vld || out_last || busy)) begin
                $display("output or busy active before the first input beat, cycle %0d", cyc);
                errors++;
            end
            if (prev_last && busy !== 1'b0) begin
                $display("busy still high in the cycle after out_last of %s", test_name);
                errors++;
            end
            if (out_vld && busy !== 1'b1) begin
                $display("busy low while beats of %s come out", test_name);
                errors++;
            end
            if (out_vld) begin
                if (exp_q.size() == 0) begin
                    $display("out_vld with no expected beat at cycle %0d", cyc);
                    errors++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    for (int l = 0; l < LANES; l++) begin
                        if (out_data[l] !== exp_beat[l]) begin
                            $display("** Error %s: beat %0d lane %0d expected %0d actual %0d",
                                     test_name, out_idx, l, exp_beat[l], out_data[l]);
                            errors++;
                        end
                    end
                end
                if (out_idx == 0 && cyc - last_in_cyc != 6) begin
                    $display("** Error %s: first out_vld latency expected 6 actual %0d",
                             test_name, cyc - last_in_cyc);
                    errors++;
                end
                if (out_idx != 0 && !prev_vld) begin
                    $display("gap in output beats of %s before beat %0d", test_name, out_idx);
                    errors++;
                end
                if (out_last !== (out_idx == BEATS - 1)) begin
                    $display("** Error %s: out_last at beat %0d expected %0d actual %0d",
                             test_name, out_idx, out_idx == BEATS - 1, out_last);
                    errors++;
                end
                out_idx = (out_idx == BEATS - 1) ? 0 : out_idx + 1;
                out_total++;
            end else if (out_last) begin
                $display("out_last high without out_vld at cycle %0d", cyc);
                errors++;
            end
            prev_vld  = out_vld;
            prev_last = out_last;
        end
    end

    initial begin
        lfsr        = 32'h7dc2_3211;
        rstn        = 1'b0;
        in_beat     = '0;
        in_vld      = 1'b0;
        shift_in    = '0;
        shift_vld   = 1'b0;
        errors      = 0;
        cyc         = 0;
        last_in_cyc = 0;
        out_idx     = 0;
        out_total   = 0;
        started     = 1'b0;
        prev_vld    = 1'b0;
        prev_last   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        // quiet period after reset
        repeat (3) @(posedge clk);
        #1;

        // x - mean is zero, so every lane should equal beta
        for (int b = 0; b < BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                vec[b].data[l]  = 8'sd37;
                vec[b].gamma[l] = 8'sd1;
                vec[b].beta[l]  = rand_elem();
            end
        end
        run_vector("const_gamma1", 4'd0);

        for (int v = 0; v < 4; v++) begin
            fill_random();
            run_vector("random", shift_t'(take_bits(4)));
        end

        fill_saturating(8'sd127);
        run_vector("saturate_pos_gamma", 4'd0);
        fill_saturating(-8'sd128);
        run_vector("saturate_neg_gamma", 4'd0);

        // same vector twice with only the shift changed
        fill_random();
        run_vector("shift_change_a", 4'd2);
        run_vector("shift_change_b", 4'd9);

        wait_idle();
        repeat (3) @(posedge clk);
        #1;
        if (exp_q.size() != 0) begin
            $display("%0d expected beats never came out", exp_q.size());
            errors++;
        end
        if (out_total != NUM_VEC * BEATS) begin
            $display("** Error beat_count: expected %0d actual %0d", NUM_VEC * BEATS, out_total);
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT * 2 * CLK_HALF);
        $display("watchdog expired after %0d cycles, DUT stopped responding; errors: %0d",
                 LIMIT, errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: layer_norm.f
src/ln_pkg.sv
src/adder_tree.sv
src/mean_accum.sv
src/beat_buffer.sv
src/affine_lanes.sv
src/layer_norm.sv
test/tb_layer_norm.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= tb_layer_norm
FILELIST  ?= layer_norm.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
